// File: Bender.yml
package:
  name: rvcore

sources:
  - files:
      - logic/rvcore_pkg.sv
      - logic/rv_fetch.sv
      - logic/rv_regfile.sv
      - logic/rv_decode.sv
      - logic/rv_execute.sv
      - logic/rvcore.sv
  - target: simulation
    files:
      - verif/rvcore_tb.sv

// File: logic/rv_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic [rvcore_pkg::xlen-1:0]       fd_inst_i,
    input  logic [rvcore_pkg::xlen-1:0]       fd_pc_i,
    input  logic                              redirect_i,
    input  logic [rvcore_pkg::xlen-1:0]       rs1_data_i,
    input  logic [rvcore_pkg::xlen-1:0]       rs2_data_i,
    output logic [rvcore_pkg::reg_addr_w-1:0] rs1_o,
    output logic [rvcore_pkg::reg_addr_w-1:0] rs2_o,
    output logic                              de_valid_o,
    output logic [rvcore_pkg::xlen-1:0]       de_op_a_o,
    output logic [rvcore_pkg::xlen-1:0]       de_op_b_o,
    output logic [rvcore_pkg::reg_addr_w-1:0] de_rs1_o,
    output logic [rvcore_pkg::reg_addr_w-1:0] de_rs2_o,
    output logic [rvcore_pkg::xlen-1:0]       de_imm_o,
    output logic [rvcore_pkg::xlen-1:0]       de_pc_o,
    output rvcore_pkg::alu_op_e               de_alu_op_o,
    output logic                              de_use_imm_o,
    output logic                              de_branch_o,
    output logic [2:0]                        de_br_f3_o,
    output logic                              de_jal_o,
    output logic [rvcore_pkg::reg_addr_w-1:0] de_rd_o,
    output logic                              de_we_o
);

    logic [6:0]                        opcode;
    logic [2:0]                        f3;
    logic [6:0]                        f7;
    logic                              alt;
    logic [rvcore_pkg::reg_addr_w-1:0] rd;
    logic [rvcore_pkg::xlen-1:0]       imm_i;
    logic [rvcore_pkg::xlen-1:0]       imm_u;
    logic [rvcore_pkg::xlen-1:0]       imm_b;
    logic [rvcore_pkg::xlen-1:0]       imm_j;
    logic [rvcore_pkg::xlen-1:0]       imm;
    rvcore_pkg::alu_op_e               alu_op;
    logic                              use_imm;
    logic                              branch;
    logic                              jal;
    logic                              wr;

    assign opcode = fd_inst_i[6:0];
    assign rd     = fd_inst_i[11:7];
    assign f3     = fd_inst_i[14:12];
    assign f7     = fd_inst_i[31:25];
    assign alt    = f7 == 7'b0100000;
    assign rs1_o  = fd_inst_i[19:15];
    assign rs2_o  = fd_inst_i[24:20];

    assign imm_i = {{20{fd_inst_i[31]}}, fd_inst_i[31:20]};
    assign imm_u = {fd_inst_i[31:12], 12'b0};
    assign imm_b = {{19{fd_inst_i[31]}}, fd_inst_i[31], fd_inst_i[7],
                    fd_inst_i[30:25], fd_inst_i[11:8], 1'b0};
    assign imm_j = {{11{fd_inst_i[31]}}, fd_inst_i[31], fd_inst_i[19:12],
                    fd_inst_i[20], fd_inst_i[30:21], 1'b0};

    always_comb begin
        alu_op  = rvcore_pkg::alu_add;
        use_imm = 1'b0;
        branch  = 1'b0;
        jal     = 1'b0;
        wr      = 1'b0;
        imm     = imm_i;
        case (opcode)
            rvcore_pkg::opc_op_imm: begin
                use_imm = 1'b1;
                wr      = 1'b1;
                case (f3)
                    rvcore_pkg::f3_add_sub: alu_op = rvcore_pkg::alu_add;
                    rvcore_pkg::f3_slt:     alu_op = rvcore_pkg::alu_slt;
                    rvcore_pkg::f3_xor:     alu_op = rvcore_pkg::alu_xor;
                    rvcore_pkg::f3_or:      alu_op = rvcore_pkg::alu_or;
                    rvcore_pkg::f3_and:     alu_op = rvcore_pkg::alu_and;
                    rvcore_pkg::f3_sll: begin
                        alu_op = rvcore_pkg::alu_sll;
                        wr     = f7 == 7'b0;
                    end
                    rvcore_pkg::f3_srl_sra: begin
                        alu_op = alt ? rvcore_pkg::alu_sra : rvcore_pkg::alu_srl;
                        wr     = alt || f7 == 7'b0;
                    end
                    // sltiu
                    default: wr = 1'b0;
                endcase
            end
            rvcore_pkg::opc_op: begin
                // funct7 of 0100000 only for sub and sra
                wr = f7 == 7'b0
                     || (alt && (f3 == rvcore_pkg::f3_add_sub || f3 == rvcore_pkg::f3_srl_sra));
                case (f3)
                    rvcore_pkg::f3_add_sub: alu_op = alt ? rvcore_pkg::alu_sub : rvcore_pkg::alu_add;
                    rvcore_pkg::f3_sll:     alu_op = rvcore_pkg::alu_sll;
                    rvcore_pkg::f3_slt:     alu_op = rvcore_pkg::alu_slt;
                    rvcore_pkg::f3_xor:     alu_op = rvcore_pkg::alu_xor;
                    rvcore_pkg::f3_srl_sra: alu_op = alt ? rvcore_pkg::alu_sra : rvcore_pkg::alu_srl;
                    rvcore_pkg::f3_or:      alu_op = rvcore_pkg::alu_or;
                    rvcore_pkg::f3_and:     alu_op = rvcore_pkg::alu_and;
                    default:                wr = 1'b0;
                endcase
            end
            rvcore_pkg::opc_lui: begin
                alu_op  = rvcore_pkg::alu_pass_b;
                use_imm = 1'b1;
                imm     = imm_u;
                wr      = 1'b1;
            end
            rvcore_pkg::opc_jal: begin
                alu_op = rvcore_pkg::alu_pass_b;
                imm    = imm_j;
                jal    = 1'b1;
                wr     = 1'b1;
            end
            rvcore_pkg::opc_branch: begin
                imm    = imm_b;
                branch = f3 == rvcore_pkg::f3_beq || f3 == rvcore_pkg::f3_bne
                         || f3 == rvcore_pkg::f3_blt || f3 == rvcore_pkg::f3_bge;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_valid_o  <= 1'b0;
            de_branch_o <= 1'b0;
            de_jal_o    <= 1'b0;
            de_we_o     <= 1'b0;
        end else begin
            // a redirect squashes the instruction now in decode
            de_valid_o  <= !redirect_i;
            de_branch_o <= branch;
            de_jal_o    <= jal;
            de_we_o     <= wr && rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        de_op_a_o    <= rs1_data_i;
        de_op_b_o    <= rs2_data_i;
        de_rs1_o     <= rs1_o;
        de_rs2_o     <= rs2_o;
        de_imm_o     <= imm;
        de_pc_o      <= fd_pc_i;
        de_alu_op_o  <= alu_op;
        de_use_imm_o <= use_imm;
        de_br_f3_o   <= f3;
        de_rd_o      <= rd;
    end

endmodule

`default_nettype wire

// File: logic/rv_execute.sv
`timescale 1ns/1ns
`default_nettype none

module rv_execute (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              de_valid_i,
    input  logic [rvcore_pkg::xlen-1:0]       de_op_a_i,
    input  logic [rvcore_pkg::xlen-1:0]       de_op_b_i,
    input  logic [rvcore_pkg::reg_addr_w-1:0] de_rs1_i,
    input  logic [rvcore_pkg::reg_addr_w-1:0] de_rs2_i,
    input  logic [rvcore_pkg::xlen-1:0]       de_imm_i,
    input  logic [rvcore_pkg::xlen-1:0]       de_pc_i,
    input  rvcore_pkg::alu_op_e               de_alu_op_i,
    input  logic                              de_use_imm_i,
    input  logic                              de_branch_i,
    input  logic [2:0]                        de_br_f3_i,
    input  logic                              de_jal_i,
    input  logic [rvcore_pkg::reg_addr_w-1:0] de_rd_i,
    input  logic                              de_we_i,
    output logic                              redirect_o,
    output logic [rvcore_pkg::xlen-1:0]       redirect_pc_o,
    output logic                              wb_we_o,
    output logic [rvcore_pkg::reg_addr_w-1:0] wb_rd_o,
    output logic [rvcore_pkg::xlen-1:0]       wb_data_o
);

    logic [rvcore_pkg::xlen-1:0] rs1_val;
    logic [rvcore_pkg::xlen-1:0] rs2_val;
    logic [rvcore_pkg::xlen-1:0] alu_a;
    logic [rvcore_pkg::xlen-1:0] alu_b;
    logic [rvcore_pkg::xlen-1:0] result;
    logic [4:0]                  shamt;
    logic                        taken;

    // older result still sitting in the writeback register
    assign rs1_val = (wb_we_o && wb_rd_o == de_rs1_i) ? wb_data_o : de_op_a_i;
    assign rs2_val = (wb_we_o && wb_rd_o == de_rs2_i) ? wb_data_o : de_op_b_i;

    assign alu_a = rs1_val;
    assign alu_b = de_jal_i     ? de_pc_i + rvcore_pkg::xlen'(4) :
                   de_use_imm_i ? de_imm_i : rs2_val;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (de_alu_op_i)
            rvcore_pkg::alu_sub:    result = alu_a - alu_b;
            rvcore_pkg::alu_sll:    result = alu_a << shamt;
            rvcore_pkg::alu_slt:    result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rvcore_pkg::alu_xor:    result = alu_a ^ alu_b;
            rvcore_pkg::alu_srl:    result = alu_a >> shamt;
            rvcore_pkg::alu_sra:    result = $signed(alu_a) >>> shamt;
            rvcore_pkg::alu_or:     result = alu_a | alu_b;
            rvcore_pkg::alu_and:    result = alu_a & alu_b;
            rvcore_pkg::alu_pass_b: result = alu_b;
            default:                result = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (de_br_f3_i)
            rvcore_pkg::f3_beq: taken = rs1_val == rs2_val;
            rvcore_pkg::f3_bne: taken = rs1_val != rs2_val;
            rvcore_pkg::f3_blt: taken = $signed(rs1_val) < $signed(rs2_val);
            rvcore_pkg::f3_bge: taken = $signed(rs1_val) >= $signed(rs2_val);
            default:            taken = 1'b0;
        endcase
    end

    // both younger slots get squashed on this pulse
    assign redirect_o    = de_valid_i && (de_jal_i || (de_branch_i && taken));
    assign redirect_pc_o = de_pc_i + de_imm_i;

    always_ff @(posedge clk) begin
        if (reset_i)
            wb_we_o <= 1'b0;
        else
            wb_we_o <= de_valid_i && de_we_i;
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= de_rd_i;
        wb_data_o <= result;
    end

    target_aligned: assert property (
        @(posedge clk) disable iff (reset_i) redirect_o |-> redirect_pc_o[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// File: logic/rv_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module rv_fetch (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        redirect_i,
    input  logic [rvcore_pkg::xlen-1:0] redirect_pc_i,
    output logic [rvcore_pkg::xlen-1:0] imem_addr_o,
    input  logic [rvcore_pkg::xlen-1:0] imem_data_i,
    output logic [rvcore_pkg::xlen-1:0] fd_inst_o,
    output logic [rvcore_pkg::xlen-1:0] fd_pc_o
);

    logic [rvcore_pkg::xlen-1:0] pc_q;
    logic [rvcore_pkg::xlen-1:0] pc_next;

    assign imem_addr_o = pc_q;
    assign pc_next     = redirect_i ? redirect_pc_i : pc_q + rvcore_pkg::xlen'(4);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q      <= rvcore_pkg::reset_pc;
            fd_inst_o <= rvcore_pkg::nop_inst;
        end else begin
            pc_q <= pc_next;
            // the word fetched behind a taken transfer is dropped
            fd_inst_o <= redirect_i ? rvcore_pkg::nop_inst : imem_data_i;
        end
    end

    always_ff @(posedge clk) begin
        fd_pc_o <= pc_q;
    end

    pc_aligned: assert property (
        @(posedge clk) disable iff (reset_i) pc_q[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// File: logic/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic [rvcore_pkg::reg_addr_w-1:0] rs1_i,
    input  logic [rvcore_pkg::reg_addr_w-1:0] rs2_i,
    output logic [rvcore_pkg::xlen-1:0]       rs1_data_o,
    output logic [rvcore_pkg::xlen-1:0]       rs2_data_o,
    input  logic                              we_i,
    input  logic [rvcore_pkg::reg_addr_w-1:0] rd_i,
    input  logic [rvcore_pkg::xlen-1:0]       rd_data_i
);

    logic [rvcore_pkg::xlen-1:0] regs_q [1:31];

    // value being written this cycle wins
    assign rs1_data_o = (rs1_i == '0)           ? '0 :
                        (we_i && rd_i == rs1_i) ? rd_data_i :
                        regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0)           ? '0 :
                        (we_i && rd_i == rs2_i) ? rd_data_i :
                        regs_q[rs2_i];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++)
                regs_q[i] <= '0;
        end else if (we_i && rd_i != '0) begin
            regs_q[rd_i] <= rd_data_i;
        end
    end

    // execute must never retire a write to x0
    no_x0_write: assert property (
        @(posedge clk) disable iff (reset_i) we_i |-> rd_i != '0
    );

endmodule

`default_nettype wire

// File: logic/rvcore.sv
`timescale 1ns/1ns
`default_nettype none

module rvcore (
    input  logic                              clk,
    input  logic                              reset_i,
    output logic [rvcore_pkg::xlen-1:0]       imem_addr_o,
    input  logic [rvcore_pkg::xlen-1:0]       imem_data_i,
    output logic                              wb_we_o,
    output logic [rvcore_pkg::reg_addr_w-1:0] wb_rd_o,
    output logic [rvcore_pkg::xlen-1:0]       wb_data_o
);

    // fetch to decode
    logic [rvcore_pkg::xlen-1:0]       fd_inst;
    logic [rvcore_pkg::xlen-1:0]       fd_pc;

    // register read
    logic [rvcore_pkg::reg_addr_w-1:0] rs1;
    logic [rvcore_pkg::reg_addr_w-1:0] rs2;
    logic [rvcore_pkg::xlen-1:0]       rs1_data;
    logic [rvcore_pkg::xlen-1:0]       rs2_data;

    // decode to execute
    logic                              de_valid;
    logic [rvcore_pkg::xlen-1:0]       de_op_a;
    logic [rvcore_pkg::xlen-1:0]       de_op_b;
    logic [rvcore_pkg::reg_addr_w-1:0] de_rs1;
    logic [rvcore_pkg::reg_addr_w-1:0] de_rs2;
    logic [rvcore_pkg::xlen-1:0]       de_imm;
    logic [rvcore_pkg::xlen-1:0]       de_pc;
    rvcore_pkg::alu_op_e               de_alu_op;
    logic                              de_use_imm;
    logic                              de_branch;
    logic [2:0]                        de_br_f3;
    logic                              de_jal;
    logic [rvcore_pkg::reg_addr_w-1:0] de_rd;
    logic                              de_we;

    logic                              redirect;
    logic [rvcore_pkg::xlen-1:0]       redirect_pc;

    rv_fetch fetch_ins (
        .clk           (clk),
        .reset_i       (reset_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .fd_inst_o     (fd_inst),
        .fd_pc_o       (fd_pc)
    );

    rv_decode decode_ins (
        .clk          (clk),
        .reset_i      (reset_i),
        .fd_inst_i    (fd_inst),
        .fd_pc_i      (fd_pc),
        .redirect_i   (redirect),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .de_valid_o   (de_valid),
        .de_op_a_o    (de_op_a),
        .de_op_b_o    (de_op_b),
        .de_rs1_o     (de_rs1),
        .de_rs2_o     (de_rs2),
        .de_imm_o     (de_imm),
        .de_pc_o      (de_pc),
        .de_alu_op_o  (de_alu_op),
        .de_use_imm_o (de_use_imm),
        .de_branch_o  (de_branch),
        .de_br_f3_o   (de_br_f3),
        .de_jal_o     (de_jal),
        .de_rd_o      (de_rd),
        .de_we_o      (de_we)
    );

    // write port fed from the same writeback triple that leaves the core
    rv_regfile regfile_ins (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_we_o),
        .rd_i       (wb_rd_o),
        .rd_data_i  (wb_data_o)
    );

    rv_execute execute_ins (
        .clk           (clk),
        .reset_i       (reset_i),
        .de_valid_i    (de_valid),
        .de_op_a_i     (de_op_a),
        .de_op_b_i     (de_op_b),
        .de_rs1_i      (de_rs1),
        .de_rs2_i      (de_rs2),
        .de_imm_i      (de_imm),
        .de_pc_i       (de_pc),
        .de_alu_op_i   (de_alu_op),
        .de_use_imm_i  (de_use_imm),
        .de_branch_i   (de_branch),
        .de_br_f3_i    (de_br_f3),
        .de_jal_i      (de_jal),
        .de_rd_i       (de_rd),
        .de_we_i       (de_we),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

`default_nettype wire

// File: logic/rvcore_pkg.sv
`default_nettype none

package rvcore_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

    // major opcodes
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // alu funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    // pass_b also carries the jal link value
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

endpackage

`default_nettype wire

// File: rvcore.f
logic/rvcore_pkg.sv
logic/rv_fetch.sv
logic/rv_regfile.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rvcore.sv
verif/rvcore_tb.sv

// File: verif/rvcore_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rvcore_tb;

    localparam int clk_period    = 20;
    localparam int drive_delay   = 2;
    localparam int reset_cycles  = 16;
    localparam int write_timeout = 20;
    localparam int idle_window   = 30;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] prog [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];

    rvcore dut (
        .clk         (clk),
        .reset_i     (reset),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .wb_we_o     (wb_we),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // words past the program read as no-ops
    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        int unsigned idx;
        idx = addr >> 2;
        if (^addr === 1'bx)
            return rvcore_pkg::nop_inst;
        if (idx < prog.size())
            return prog[idx];
        return rvcore_pkg::nop_inst;
    endfunction

    task automatic expect_write(input logic [4:0] rd, input logic [31:0] val);
        exp_rd.push_back(rd);
        exp_val.push_back(val);
    endtask

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_for_write(input int idx);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_we && cycles < write_timeout);
        if (!wb_we) begin
            $display("Write %0d to x%0d never arrived within %0d cycles",
                     idx, exp_rd[idx], write_timeout);
            abort_run();
        end
    endtask

    task automatic load_program();
        // alu results and signed compares
        prog.push_back(i_type(3'b000, 1, 0, 12'h005));
        prog.push_back(i_type(3'b000, 2, 0, 12'hffd));
        prog.push_back(r_type(7'h00, 3'b000, 3, 1, 2));
        prog.push_back(r_type(7'h20, 3'b000, 4, 1, 2));
        prog.push_back(r_type(7'h00, 3'b010, 5, 2, 1));
        prog.push_back(r_type(7'h00, 3'b010, 6, 1, 2));
        prog.push_back(r_type(7'h00, 3'b100, 7, 1, 2));
        prog.push_back(r_type(7'h00, 3'b110, 8, 1, 2));
        prog.push_back(r_type(7'h00, 3'b111, 9, 1, 2));
        prog.push_back(r_type(7'h00, 3'b001, 10, 1, 1));
        prog.push_back(r_type(7'h00, 3'b101, 11, 2, 1));
        prog.push_back(r_type(7'h20, 3'b101, 12, 2, 1));
        prog.push_back(i_type(3'b001, 13, 1, 12'h004));
        prog.push_back(i_type(3'b101, 14, 2, 12'h01c));
        prog.push_back(i_type(3'b101, 15, 2, 12'h401));
        prog.push_back(i_type(3'b010, 16, 2, 12'hffe));
        prog.push_back(i_type(3'b100, 17, 1, 12'h0ff));
        prog.push_back(i_type(3'b110, 18, 1, 12'h030));
        prog.push_back(i_type(3'b111, 19, 2, 12'h0f0));
        // lui, then a back-to-back dependency chain
        prog.push_back(u_type(20, 20'h12345));
        prog.push_back(i_type(3'b000, 20, 20, 12'h678));
        prog.push_back(i_type(3'b000, 21, 20, 12'h001));
        prog.push_back(r_type(7'h00, 3'b000, 22, 21, 20));
        // write to x0 then read it
        prog.push_back(i_type(3'b000, 0, 1, 12'h007));
        prog.push_back(r_type(7'h00, 3'b000, 23, 0, 1));
        // branches, taken ones skip two slots
        prog.push_back(b_type(3'b000, 1, 1, 13'd12));
        prog.push_back(i_type(3'b000, 24, 0, 12'h001));
        prog.push_back(i_type(3'b000, 24, 0, 12'h002));
        prog.push_back(b_type(3'b001, 1, 1, 13'd8));
        prog.push_back(i_type(3'b000, 25, 0, 12'd11));
        prog.push_back(i_type(3'b000, 26, 0, 12'd12));
        prog.push_back(b_type(3'b001, 1, 2, 13'd12));
        prog.push_back(i_type(3'b000, 27, 0, 12'h001));
        prog.push_back(i_type(3'b000, 27, 0, 12'h002));
        prog.push_back(b_type(3'b100, 2, 1, 13'd12));
        prog.push_back(i_type(3'b000, 28, 0, 12'h001));
        prog.push_back(i_type(3'b000, 28, 0, 12'h002));
        prog.push_back(b_type(3'b100, 1, 2, 13'd8));
        prog.push_back(i_type(3'b000, 28, 0, 12'd21));
        prog.push_back(b_type(3'b101, 1, 2, 13'd12));
        prog.push_back(i_type(3'b000, 29, 0, 12'h001));
        prog.push_back(i_type(3'b000, 29, 0, 12'h002));
        prog.push_back(b_type(3'b101, 2, 1, 13'd8));
        prog.push_back(i_type(3'b000, 29, 0, 12'd31));
        // jal links pc + 4, at index 44
        prog.push_back(j_type(30, 21'd12));
        prog.push_back(i_type(3'b000, 31, 0, 12'h001));
        prog.push_back(i_type(3'b000, 31, 0, 12'h002));
        prog.push_back(r_type(7'h00, 3'b000, 31, 30, 23));
        prog.push_back(b_type(3'b000, 1, 2, 13'd8));
        prog.push_back(i_type(3'b000, 24, 0, 12'h007));
        prog.push_back(b_type(3'b001, 24, 0, 13'd12));
        prog.push_back(i_type(3'b000, 27, 0, 12'h001));
        prog.push_back(i_type(3'b000, 27, 0, 12'h002));
        prog.push_back(i_type(3'b000, 27, 24, 12'h001));
        prog.push_back(j_type(0, 21'd8));
        prog.push_back(i_type(3'b000, 26, 0, 12'd99));
        prog.push_back(i_type(3'b000, 26, 26, 12'h001));
    endtask

    task automatic load_expected();
        expect_write(1, 32'h0000_0005);
        expect_write(2, 32'hffff_fffd);
        expect_write(3, 32'h0000_0002);
        expect_write(4, 32'h0000_0008);
        expect_write(5, 32'h0000_0001);
        expect_write(6, 32'h0000_0000);
        expect_write(7, 32'hffff_fff8);
        expect_write(8, 32'hffff_fffd);
        expect_write(9, 32'h0000_0005);
        expect_write(10, 32'h0000_00a0);
        expect_write(11, 32'h07ff_ffff);
        expect_write(12, 32'hffff_ffff);
        expect_write(13, 32'h0000_0050);
        expect_write(14, 32'h0000_000f);
        expect_write(15, 32'hffff_fffe);
        expect_write(16, 32'h0000_0001);
        expect_write(17, 32'h0000_00fa);
        expect_write(18, 32'h0000_0035);
        expect_write(19, 32'h0000_00f0);
        expect_write(20, 32'h1234_5000);
        expect_write(20, 32'h1234_5678);
        expect_write(21, 32'h1234_5679);
        expect_write(22, 32'h2468_acf1);
        expect_write(23, 32'h0000_0005);
        expect_write(25, 32'h0000_000b);
        expect_write(26, 32'h0000_000c);
        expect_write(28, 32'h0000_0015);
        expect_write(29, 32'h0000_001f);
        expect_write(30, 32'h0000_00b4);
        expect_write(31, 32'h0000_00b9);
        expect_write(24, 32'h0000_0007);
        expect_write(27, 32'h0000_0008);
        expect_write(26, 32'h0000_000d);
    endtask

    // instruction memory answers shortly after the pc moves
    always @(posedge clk) begin
        #drive_delay;
        imem_data = rom_word(imem_addr);
    end

    initial begin
        reset     = 1'b1;
        imem_data = rvcore_pkg::nop_inst;
        load_program();
        load_expected();

        for (int c = 0; c < reset_cycles; c++) begin
            @(negedge clk);
            check_value("wb_we_o", 32'(wb_we), 32'h0);
            check_value("imem_addr_o", imem_addr, rvcore_pkg::reset_pc);
        end
        @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        // first fetch out of reset
        @(negedge clk);
        check_value("imem_addr_o", imem_addr, rvcore_pkg::reset_pc);

        for (int i = 0; i < exp_rd.size(); i++) begin
            wait_for_write(i);
            check_value("wb_rd_o", 32'(wb_rd), 32'(exp_rd[i]));
            check_value("wb_data_o", wb_data, exp_val[i]);
        end

        // nothing else may retire
        for (int c = 0; c < idle_window; c++) begin
            @(negedge clk);
            if (wb_we) begin
                $display("Unexpected write to x%0d of 0x%08h after the last expected write",
                         wb_rd, wb_data);
                abort_run();
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
